// File: all.f
+incdir+src
src/switch_pkg.sv
src/ingress_parser.sv
src/voq_buffer.sv
src/egress_scheduler.sv
src/packet_switch_top.sv
tb/packet_switch_checker.sv
tb/packet_switch_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the packet switch testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module packet_switch_tb -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/sim +verilator+error+limit+100)
sim_status=$?
printf '%s\n' "$output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status."
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: src/egress_scheduler.sv
`include "switch_params.svh"

module egress_scheduler
    import switch_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ready,
    input  logic [`PORT_COUNT-1:0] empty,
    input  voq_entry_t             rd_entry,
    output logic                   rd_en,
    output port_idx_t              rd_sel,
    output logic                   rd_sop,
    output logic                   rd_eop,
    output logic                   rd_vld,
    output word_t                  rd_data
);

    localparam int NUM_PORTS = `PORT_COUNT;

    sched_state_t state;
    port_idx_t    grant_idx;
    logic         grant_hit;
    logic         first_word;
    logic         eop_seen;

    // The eop word is only known once it comes back from the buffer.
    assign eop_seen = rd_vld && rd_entry.eop;

    // No read ahead once the eop word has arrived.
    assign rd_en = (state == SCHED_BURST) && ready && !empty[rd_sel] && !eop_seen;

    assign rd_eop  = eop_seen;
    assign rd_data = rd_entry.data;

    // Round robin: rd_sel still names the input served last.
    always_comb begin
        port_idx_t cand;
        grant_hit = 1'b0;
        grant_idx = rd_sel;
        cand      = rd_sel;
        // Farthest first, so the nearest non-empty input wins.
        for (int k = NUM_PORTS; k >= 1; k--) begin
            cand = rd_sel + port_idx_t'(k);
            if (!empty[cand]) begin
                grant_hit = 1'b1;
                grant_idx = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= SCHED_IDLE;
            rd_sel     <= port_idx_t'(NUM_PORTS - 1);  // Input 0 goes first.
            first_word <= 1'b0;
            rd_vld     <= 1'b0;
            rd_sop     <= 1'b0;
        end else begin
            rd_vld <= rd_en;
            rd_sop <= rd_en && first_word;
            if (rd_en) begin
                first_word <= 1'b0;
            end
            case (state)
                SCHED_IDLE: begin
                    if (grant_hit) begin
                        state      <= SCHED_BURST;
                        rd_sel     <= grant_idx;
                        first_word <= 1'b1;
                    end
                end
                SCHED_BURST: begin
                    if (eop_seen) begin
                        state <= SCHED_IDLE;  // Packet fully drained.
                    end
                end
                default: begin
                    state <= SCHED_IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/ingress_parser.sv
module ingress_parser
    import switch_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          wr_sop,
    input  logic          wr_eop,
    input  logic          wr_vld,
    input  word_t         wr_data,
    output ingress_beat_t beat
);

    logic      in_packet;
    logic      accept;
    port_idx_t hdr_dest;
    port_idx_t dest_q;
    logic      beat_vld;
    logic      beat_eop;
    port_idx_t beat_dest;
    word_t     beat_data;

    // A header always opens a packet, other words need one open.
    assign accept   = wr_vld && (wr_sop || in_packet);
    assign hdr_dest = wr_data[$bits(port_idx_t)-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            in_packet <= 1'b0;
            beat_vld  <= 1'b0;
            beat_eop  <= 1'b0;
        end else begin
            if (accept) begin
                in_packet <= !wr_eop;  // One-word packet closes at once.
            end
            beat_vld <= accept;
            beat_eop <= accept && wr_eop;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && wr_sop) begin
            dest_q <= hdr_dest;
        end
        if (accept) begin
            beat_dest <= wr_sop ? hdr_dest : dest_q;
            beat_data <= wr_data;
        end
    end

    assign beat = '{vld: beat_vld, eop: beat_eop, dest: beat_dest, data: beat_data};

endmodule

// File: src/packet_switch_top.sv
`include "switch_params.svh"

module packet_switch_top
    import switch_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`PORT_COUNT-1:0] wr_sop,
    input  logic [`PORT_COUNT-1:0] wr_eop,
    input  logic [`PORT_COUNT-1:0] wr_vld,
    input  word_t                  wr_data [`PORT_COUNT],
    output wire  [`PORT_COUNT-1:0] rd_sop,
    output wire  [`PORT_COUNT-1:0] rd_eop,
    output wire  [`PORT_COUNT-1:0] rd_vld,
    output wire  word_t            rd_data [`PORT_COUNT],
    output logic                   full,
    input  logic [`PORT_COUNT-1:0] ready
);

    wire  ingress_beat_t          beats [`PORT_COUNT];
    wire  [`PORT_COUNT-1:0]       rd_en;
    wire  port_idx_t              rd_sel [`PORT_COUNT];
    logic [`PORT_COUNT-1:0]       empty [`PORT_COUNT];
    voq_entry_t                   rd_entry [`PORT_COUNT];

    voq_buffer u_buffer (
        .clk      (clk),
        .reset    (reset),
        .beats    (beats),
        .rd_en    (rd_en),
        .rd_sel   (rd_sel),
        .empty    (empty),
        .rd_entry (rd_entry),
        .full     (full)
    );

    for (genvar p = 0; p < `PORT_COUNT; p++) begin : g_port
        ingress_parser u_parser (
            .clk     (clk),
            .reset   (reset),
            .wr_sop  (wr_sop[p]),
            .wr_eop  (wr_eop[p]),
            .wr_vld  (wr_vld[p]),
            .wr_data (wr_data[p]),
            .beat    (beats[p])
        );

        egress_scheduler u_sched (
            .clk      (clk),
            .reset    (reset),
            .ready    (ready[p]),
            .empty    (empty[p]),
            .rd_entry (rd_entry[p]),
            .rd_en    (rd_en[p]),
            .rd_sel   (rd_sel[p]),
            .rd_sop   (rd_sop[p]),
            .rd_eop   (rd_eop[p]),
            .rd_vld   (rd_vld[p]),
            .rd_data  (rd_data[p])
        );
    end

endmodule

// File: src/switch_params.svh
`ifndef SWITCH_PARAMS_SVH
`define SWITCH_PARAMS_SVH

// Number of input and output ports.
`define PORT_COUNT 4

// Data width of one packet word.
`define WORD_WIDTH 16

// Words per virtual output queue, a power of two.
`define VOQ_DEPTH 16

// Largest legal packet, header included.
`define MAX_PKT_WORDS 6

`endif

// File: src/switch_pkg.sv
`include "switch_params.svh"

package switch_pkg;

    typedef logic [$clog2(`PORT_COUNT)-1:0] port_idx_t;
    typedef logic [`WORD_WIDTH-1:0]         word_t;
    typedef logic [$clog2(`VOQ_DEPTH):0]    voq_count_t;  // Holds 0 to VOQ_DEPTH.

    // One accepted word on its way from a parser into the buffer.
    typedef struct packed {
        logic      vld;
        logic      eop;
        port_idx_t dest;
        word_t     data;
    } ingress_beat_t;

    typedef struct packed {
        logic  eop;
        word_t data;
    } voq_entry_t;

    typedef enum logic {
        SCHED_IDLE,
        SCHED_BURST
    } sched_state_t;

endpackage

// File: src/voq_buffer.sv
`include "switch_params.svh"

module voq_buffer
    import switch_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  ingress_beat_t          beats [`PORT_COUNT],
    input  logic [`PORT_COUNT-1:0] rd_en,
    input  port_idx_t              rd_sel [`PORT_COUNT],
    output logic [`PORT_COUNT-1:0] empty [`PORT_COUNT],
    output voq_entry_t             rd_entry [`PORT_COUNT],
    output logic                   full
);

    localparam int NUM_PORTS  = `PORT_COUNT;
    localparam int NUM_QUEUES = NUM_PORTS * NUM_PORTS;
    localparam int PTR_W      = $clog2(`VOQ_DEPTH);
    localparam voq_count_t FULL_LEVEL = voq_count_t'(`VOQ_DEPTH - `MAX_PKT_WORDS - 1);

    // Queue q = {input, output}, so input is q / NUM_PORTS.
    voq_entry_t            mem [NUM_QUEUES][`VOQ_DEPTH];
    logic [PTR_W-1:0]      wr_ptr [NUM_QUEUES];
    logic [PTR_W-1:0]      rd_ptr [NUM_QUEUES];
    voq_count_t            count [NUM_QUEUES];
    logic [NUM_QUEUES-1:0] push;
    logic [NUM_QUEUES-1:0] pop;
    logic [NUM_QUEUES-1:0] near_full;

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            push[q] = beats[q / NUM_PORTS].vld
                   && (beats[q / NUM_PORTS].dest == port_idx_t'(q % NUM_PORTS));
            pop[q]  = rd_en[q % NUM_PORTS]
                   && (rd_sel[q % NUM_PORTS] == port_idx_t'(q / NUM_PORTS));
            // Counts the beat being written now.
            // One more slot stays back for the word still inside the parser.
            near_full[q] = (count[q] + voq_count_t'(push[q])) > FULL_LEVEL;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                count[q]  <= '0;
            end
            full <= 1'b0;
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (push[q]) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;  // Wraps, depth is a power of two.
                end
                if (pop[q]) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                count[q] <= count[q] + voq_count_t'(push[q]) - voq_count_t'(pop[q]);
            end
            full <= |near_full;
        end
    end

    always_ff @(posedge clk) begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (push[q]) begin
                mem[q][wr_ptr[q]] <= '{eop:  beats[q / NUM_PORTS].eop,
                                       data: beats[q / NUM_PORTS].data};
            end
        end
    end

    // Popped head shows up one cycle after rd_en.
    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (rd_en[o]) begin
                rd_entry[o] <= mem[{rd_sel[o], port_idx_t'(o)}]
                                  [rd_ptr[{rd_sel[o], port_idx_t'(o)}]];
            end
        end
    end

    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                empty[o][i] = (count[i * NUM_PORTS + o] == '0);
            end
        end
    end

endmodule

// File: tb/packet_switch_checker.sv
`include "switch_params.svh"

module packet_switch_checker (
    input logic                   clk,
    input logic                   reset,
    input logic [`PORT_COUNT-1:0] ready,
    input logic [`PORT_COUNT-1:0] rd_sop,
    input logic [`PORT_COUNT-1:0] rd_vld,
    input logic                   full
);
    timeunit 1ns;
    timeprecision 1ps;

    int sop_errors   = 0;
    int pause_errors = 0;
    int reset_errors = 0;

    // Start of packet only on a valid word.
    sop_with_vld: assert property (@(posedge clk) disable iff (reset)
        (rd_sop & ~rd_vld) == '0)
        else begin
            $error("rd_sop %b raised without rd_vld %b", rd_sop, rd_vld);
            sop_errors++;
        end

    pause_stops_output: assert property (@(posedge clk) disable iff (reset)
        (rd_vld & ~$past(ready)) == '0)  // No read is issued while ready is low.
        else begin
            $error("rd_vld %b one cycle after ready was low", rd_vld);
            pause_errors++;
        end

    // Registers settle during reset and stay quiet.
    quiet_in_reset: assert property (@(posedge clk) reset |=> (!full && rd_vld == '0))
        else begin
            $error("full %b or rd_vld %b high in reset", full, rd_vld);
            reset_errors++;
        end

endmodule

// File: tb/packet_switch_tb.sv
`include "switch_params.svh"

module packet_switch_tb
    import switch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS = `PORT_COUNT;

    typedef struct packed {
        logic [2:0]  len;
        logic [11:0] seq;
    } exp_pkt_t;

    logic                 clk;
    logic                 reset = 1'b1;
    logic [NUM_PORTS-1:0] wr_sop = '0;
    logic [NUM_PORTS-1:0] wr_eop = '0;
    logic [NUM_PORTS-1:0] wr_vld = '0;
    word_t                wr_data [NUM_PORTS] = '{default: '0};
    logic [NUM_PORTS-1:0] ready = '0;
    wire  [NUM_PORTS-1:0] rd_sop;
    wire  [NUM_PORTS-1:0] rd_eop;
    wire  [NUM_PORTS-1:0] rd_vld;
    word_t                rd_data [NUM_PORTS];
    logic                 full;

    logic [15:0] lfsr = 16'd93;
    int          pkts_left [NUM_PORTS] = '{default: 0};
    int          dest_sel [NUM_PORTS] = '{default: -1};  // Negative means random.
    int          fixed_len = 0;  // Zero means random.
    int          ready_mode = 0;
    int          words_left [NUM_PORTS] = '{default: 0};
    int          gap [NUM_PORTS] = '{default: 0};
    port_idx_t   cur_dest [NUM_PORTS];
    exp_pkt_t    cur_pkt [NUM_PORTS];
    logic [2:0]  cur_idx [NUM_PORTS];
    logic [11:0] seq_next [NUM_PORTS][NUM_PORTS] = '{default: '0};
    exp_pkt_t    exp_q [NUM_PORTS][NUM_PORTS][$];  // Indexed by source, then output.
    int          sent_words = 0;
    int          rcvd_words = 0;
    logic        mon_open [NUM_PORTS] = '{default: 1'b0};
    port_idx_t   mon_src [NUM_PORTS];
    exp_pkt_t    mon_pkt [NUM_PORTS];
    logic [2:0]  mon_idx [NUM_PORTS];

    packet_switch_top UUT (
        .clk     (clk),
        .reset   (reset),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data),
        .full    (full),
        .ready   (ready)
    );

    bind packet_switch_top packet_switch_checker u_checker (
        .clk    (clk),
        .reset  (reset),
        .ready  (ready),
        .rd_sop (rd_sop),
        .rd_vld (rd_vld),
        .full   (full)
    );

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Header is {seq, src, dest}, payload mixes all fields with the word index.
    function automatic word_t packet_word(input port_idx_t src, input port_idx_t dest,
                                         input logic [11:0] seq, input logic [2:0] idx);
        if (idx == 3'd0) begin
            return {seq, src, dest};
        end
        return {seq[7:0] ^ 8'h5A, idx, 1'b1, dest, src};
    endfunction

    function automatic int checker_failures();
        return UUT.u_checker.sop_errors + UUT.u_checker.pause_errors
             + UUT.u_checker.reset_errors;
    endfunction

    function automatic logic traffic_done();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (pkts_left[p] != 0 || words_left[p] != 0 || mon_open[p]) begin
                return 1'b0;
            end
        end
        return rcvd_words == sent_words;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped after a failed check.");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        while (!traffic_done()) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf("Traffic did not drain within %0d cycles.", limit));
            end
        end
    endtask

    task automatic wait_full(input logic level, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (full !== level) begin
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf("Full did not reach %0b within %0d cycles.", level, limit));
            end
            @(negedge clk);
        end
    endtask

    task automatic start_traffic(input int pkts, input int dest, input int step,
                                 input int len, input int mode);
        @(posedge clk);
        fixed_len  = len;
        ready_mode = mode;
        for (int p = 0; p < NUM_PORTS; p++) begin
            pkts_left[p] = pkts;
            dest_sel[p]  = (dest < 0) ? -1 : (dest + step * p) % NUM_PORTS;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Traffic generator for all inputs.
    always @(negedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            case (ready_mode)
                0: ready[p] = 1'b1;
                1: ready[p] = (rand_bits(2) != 16'd0);
                default: ready[p] = (p != 0);  // Output 0 held off.
            endcase
            wr_vld[p] = 1'b0;
            wr_sop[p] = 1'b0;
            wr_eop[p] = 1'b0;
            if (words_left[p] > 0) begin
                wr_vld[p]  = 1'b1;
                wr_data[p] = packet_word(port_idx_t'(p), cur_dest[p], cur_pkt[p].seq,
                                         cur_idx[p]);
                cur_idx[p]++;
                words_left[p]--;
                wr_eop[p] = (words_left[p] == 0);
            end else if (gap[p] > 0) begin
                gap[p]--;
                if (rand_bits(2) == 16'd0) begin  // Stray word.
                    wr_vld[p]  = 1'b1;
                    wr_data[p] = rand_bits(16);
                end
            end else if (pkts_left[p] > 0 && !full) begin
                cur_pkt[p].len = (fixed_len > 0) ? 3'(fixed_len)
                                                 : 3'(rand_bits(3) % 16'd6 + 16'd1);
                cur_dest[p] = (dest_sel[p] < 0) ? port_idx_t'(rand_bits(2))
                                                : port_idx_t'(dest_sel[p]);
                cur_pkt[p].seq = seq_next[p][cur_dest[p]];
                seq_next[p][cur_dest[p]]++;
                exp_q[p][cur_dest[p]].push_back(cur_pkt[p]);
                wr_vld[p]     = 1'b1;
                wr_sop[p]     = 1'b1;
                wr_data[p]    = packet_word(port_idx_t'(p), cur_dest[p], cur_pkt[p].seq, 3'd0);
                cur_idx[p]    = 3'd1;
                words_left[p] = int'(cur_pkt[p].len) - 1;
                wr_eop[p]     = (words_left[p] == 0);
                sent_words += int'(cur_pkt[p].len);
                pkts_left[p]--;
            end
            if (wr_eop[p]) begin
                gap[p] = int'(rand_bits(2));
            end
        end
    end

    // Output monitor and scoreboard.
    always @(negedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rd_vld[p]) begin
                if (rd_sop[p]) begin
                    if (mon_open[p]) begin
                        abort_run($sformatf("Output %0d started a packet inside another.", p));
                    end
                    mon_src[p] = rd_data[p][3:2];
                    if (exp_q[mon_src[p]][p].size() == 0) begin
                        abort_run($sformatf("Unexpected packet from input %0d on output %0d.",
                                            mon_src[p], p));
                    end
                    mon_pkt[p]  = exp_q[mon_src[p]][p].pop_front();
                    mon_idx[p]  = 3'd0;
                    mon_open[p] = 1'b1;
                end else if (!mon_open[p]) begin
                    abort_run($sformatf("Output %0d sent a word outside any packet.", p));
                end
                compare_value($sformatf("rd_data[%0d]", p), 32'(rd_data[p]),
                              32'(packet_word(mon_src[p], port_idx_t'(p), mon_pkt[p].seq,
                                              mon_idx[p])));
                compare_value($sformatf("rd_eop[%0d]", p), 32'(rd_eop[p]),
                              32'(mon_idx[p] == mon_pkt[p].len - 3'd1));
                mon_open[p] = !rd_eop[p];
                mon_idx[p]++;
                rcvd_words++;
            end
        end
        if (checker_failures() != 0) begin
            abort_run("An assertion in the checker failed.");
        end
    end

    initial begin
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compare_value("rd_vld", 32'(rd_vld), 32'd0);
        compare_value("full", 32'(full), 32'd0);
        start_traffic(1, 1, 1, 1, 0);  // One-word packets, input p to output p+1.
        wait_drained(200);
        start_traffic(60, -1, 0, 0, 0);
        wait_drained(20000);
        start_traffic(60, -1, 0, 0, 1);
        wait_drained(40000);
        // Everything to output 0 while it is held off.
        start_traffic(12, 0, 0, 0, 2);
        wait_full(1'b1, 1000);
        repeat (40) @(posedge clk);
        ready_mode = 0;
        wait_drained(5000);
        wait_full(1'b0, 100);
        for (int s = 0; s < NUM_PORTS; s++) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (exp_q[s][o].size() != 0) begin
                    abort_run($sformatf("Packets from input %0d to output %0d never arrived.",
                                        s, o));
                end
            end
        end
        if (checker_failures() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("The checker reported assertion failures.");
        end
    end

endmodule
